// ==== Makefile ====
# Verilator build and run of the execute back end testbench

SIM    ?= verilator
TOP    ?= tb_exec_core
FLIST  ?= list.f
BUILD  ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
LOG    ?= sim.log

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FLIST) $(SRCS)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit import ex_pkg::*; (
    ex_issue_if.exec        exec,
    output logic [xlen-1:0] o_result
);

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] diff;
    logic [4:0]      shamt;
    logic            sign_a;
    logic            sign_b;
    logic            lt_signed;
    logic            lt_unsigned;

    assign a      = exec.operand_a;
    assign b      = exec.operand_b;
    assign diff   = a - b;
    assign shamt  = b[4:0];
    assign sign_a = a[xlen-1];
    assign sign_b = b[xlen-1];

    // With equal signs the difference cannot overflow
    assign lt_signed   = (sign_a != sign_b) ? sign_a : diff[xlen-1];
    assign lt_unsigned = (sign_a != sign_b) ? sign_b : diff[xlen-1];

    always_comb begin
        case (exec.alu_op)
            alu_add:  o_result = a + b;
            alu_sub:  o_result = diff;
            alu_sll:  o_result = a << shamt;
            alu_slt:  o_result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: o_result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:  o_result = a ^ b;
            alu_srl:  o_result = a >> shamt;
            alu_sra:  o_result = $unsigned($signed(a) >>> shamt);
            alu_or:   o_result = a | b;
            alu_and:  o_result = a & b;
            default:  o_result = '0;
        endcase
    end

endmodule

// ==== ex_pkg.sv ====
package ex_pkg;

    // Datapath and register index widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // Major opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;

    // funct7 selectors
    localparam logic [6:0] funct7_alt    = 7'b0100000;
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

    // funct3 codes of the OP and OP-IMM groups
    localparam logic [2:0] f3_add  = 3'd0;
    localparam logic [2:0] f3_sll  = 3'd1;
    localparam logic [2:0] f3_slt  = 3'd2;
    localparam logic [2:0] f3_sltu = 3'd3;
    localparam logic [2:0] f3_xor  = 3'd4;
    localparam logic [2:0] f3_sr   = 3'd5;
    localparam logic [2:0] f3_or   = 3'd6;
    localparam logic [2:0] f3_and  = 3'd7;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } insn_r_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } insn_i_t;

    // One instruction word, read as R-type or I-type depending on the opcode
    typedef union packed {
        insn_r_t r;
        insn_i_t i;
    } insn_u;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    // Encoding follows funct3 of the M extension
    typedef enum logic [1:0] {
        mul_mul, mul_mulh, mul_mulhsu, mul_mulhu
    } mul_op_e;

    typedef enum logic {
        unit_alu, unit_mul
    } unit_e;

endpackage

// ==== ex_stage_if.sv ====
`timescale 1ns/1ps

// Issue bundle from the decode-to-execute slot to the execution units
interface ex_issue_if import ex_pkg::*; ();
    logic                  issue_valid;
    unit_e                 unit;
    alu_op_e               alu_op;
    mul_op_e               mul_op;
    logic [xlen-1:0]       operand_a;
    logic [xlen-1:0]       operand_b;
    logic [reg_addr_w-1:0] rd;

    modport issue (output issue_valid, unit, alu_op, mul_op, operand_a, operand_b, rd);
    modport exec  (input issue_valid, unit, alu_op, mul_op, operand_a, operand_b);
    modport track (input issue_valid, unit, rd);
endinterface

// Status of the two EX stages for operand forwarding
interface ex_fwd_if import ex_pkg::*; ();
    logic                  ex1_pending;
    logic [reg_addr_w-1:0] ex1_rd;
    logic                  ex1_data_valid;
    logic [xlen-1:0]       ex1_data;
    logic                  ex2_pending;
    logic [reg_addr_w-1:0] ex2_rd;
    logic                  ex2_data_valid;
    logic [xlen-1:0]       ex2_data;
    logic                  ex1_free;

    modport source (output ex1_pending, ex1_rd, ex1_data_valid, ex1_data,
                    ex2_pending, ex2_rd, ex2_data_valid, ex2_data, ex1_free);
    modport sink   (input ex1_pending, ex1_rd, ex1_data_valid, ex1_data,
                    ex2_pending, ex2_rd, ex2_data_valid, ex2_data, ex1_free);
endinterface

// ==== exec_core.sv ====
`timescale 1ns/1ps

module exec_core import ex_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  i_valid,
    output logic                  o_ready,
    input  insn_u                 i_insn,
    output logic                  o_wb_valid,
    output logic [reg_addr_w-1:0] o_wb_rd,
    output logic [xlen-1:0]       o_wb_data
);

    logic [reg_addr_w-1:0] rs1_sel;
    logic [reg_addr_w-1:0] rs2_sel;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       mul_result;
    logic                  mul_ready;
    logic                  mul_valid;

    ex_issue_if issue_bus ();
    ex_fwd_if   fwd_bus ();

    issue_stage issue_i (
        .clk         (clk),
        .resetn      (resetn),
        .i_valid     (i_valid),
        .o_ready     (o_ready),
        .i_insn      (i_insn),
        .o_rs1_sel   (rs1_sel),
        .o_rs2_sel   (rs2_sel),
        .i_rs1_data  (rs1_data),
        .i_rs2_data  (rs2_data),
        .i_mul_ready (mul_ready),
        .issue       (issue_bus.issue),
        .fwd         (fwd_bus.sink)
    );

    reg_file reg_file_i (
        .clk        (clk),
        .resetn     (resetn),
        .i_rs1_sel  (rs1_sel),
        .o_rs1_data (rs1_data),
        .i_rs2_sel  (rs2_sel),
        .o_rs2_data (rs2_data),
        .i_we       (o_wb_valid),
        .i_wd_sel   (o_wb_rd),
        .i_wd_data  (o_wb_data)
    );

    alu_unit alu_i (
        .exec     (issue_bus.exec),
        .o_result (alu_result)
    );

    mul_unit mul_i (
        .clk      (clk),
        .resetn   (resetn),
        .exec     (issue_bus.exec),
        .o_ready  (mul_ready),
        .o_valid  (mul_valid),
        .o_result (mul_result)
    );

    result_pipe result_pipe_i (
        .clk          (clk),
        .resetn       (resetn),
        .track        (issue_bus.track),
        .i_alu_result (alu_result),
        .i_mul_valid  (mul_valid),
        .i_mul_result (mul_result),
        .fwd          (fwd_bus.source),
        .o_wb_valid   (o_wb_valid),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data)
    );

endmodule

// ==== exec_core_assert.sv ====
`timescale 1ns/1ps

module exec_core_assert import ex_pkg::*; (
    input logic                  clk,
    input logic                  resetn,
    input logic                  i_issue_valid,
    input logic                  i_ex1_wait,
    input logic                  i_ex1_move,
    input logic                  i_ex2_pending,
    input logic                  i_wb_valid,
    input logic [reg_addr_w-1:0] i_wb_rd,
    input logic [xlen-1:0]       i_wb_data
);

    // A retired entry leaves EX2 empty unless EX1 moves in on the same edge
    wb_from_ex2: assert property (@(posedge clk) disable iff (!resetn)
        (i_wb_valid && !i_ex1_move) |=> !i_ex2_pending)
        else $error("EX2 still occupied after its entry retired");

    // A stage waiting on the multiplier may only be replaced when it moves on
    ex1_hold_on_mul: assert property (@(posedge clk) disable iff (!resetn)
        (i_issue_valid && i_ex1_wait) |-> i_ex1_move)
        else $error("issue into EX1 while it waits on the multiplier");

    wb_known: assert property (@(posedge clk) disable iff (!resetn)
        i_wb_valid |-> !$isunknown({i_wb_rd, i_wb_data}))
        else $error("writeback rd or data unknown during a retirement");

endmodule

bind result_pipe exec_core_assert assert_i (
    .clk           (clk),
    .resetn        (resetn),
    .i_issue_valid (track.issue_valid),
    .i_ex1_wait    (ex1_wait),
    .i_ex1_move    (ex1_move),
    .i_ex2_pending (ex2_pending),
    .i_wb_valid    (o_wb_valid),
    .i_wb_rd       (o_wb_rd),
    .i_wb_data     (o_wb_data)
);

// ==== issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage import ex_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  i_valid,
    output logic                  o_ready,
    input  insn_u                 i_insn,
    output logic [reg_addr_w-1:0] o_rs1_sel,
    output logic [reg_addr_w-1:0] o_rs2_sel,
    input  logic [xlen-1:0]       i_rs1_data,
    input  logic [xlen-1:0]       i_rs2_data,
    input  logic                  i_mul_ready,
    ex_issue_if.issue             issue,
    ex_fwd_if.sink                fwd
);

    // Decoded fields of the incoming word
    unit_e                 dec_unit;
    alu_op_e               dec_alu_op;
    logic [reg_addr_w-1:0] dec_rs1;
    logic [reg_addr_w-1:0] dec_rs2;
    logic                  dec_use_imm;
    logic [xlen-1:0]       dec_imm;
    logic [2:0]            f3;
    logic                  alt;

    // Decode-to-execute slot
    logic                  slot_valid;
    unit_e                 slot_unit;
    alu_op_e               slot_alu_op;
    mul_op_e               slot_mul_op;
    logic [reg_addr_w-1:0] slot_rd;
    logic [reg_addr_w-1:0] slot_rs1;
    logic [reg_addr_w-1:0] slot_rs2;
    logic                  slot_use_imm;
    logic [xlen-1:0]       slot_imm;

    logic [reg_addr_w-1:0] src_sel [2];
    logic [xlen-1:0]       src_rf  [2];
    logic [xlen-1:0]       src_val [2];
    logic [1:0]            src_stall;
    logic                  can_issue;

    always_comb begin
        dec_unit    = unit_alu;
        dec_use_imm = 1'b0;
        dec_imm     = '0;
        if (i_insn.r.opcode == opc_op_imm) begin
            dec_use_imm = 1'b1;
            dec_rs1     = i_insn.i.rs1;
            dec_rs2     = '0;
            f3          = i_insn.i.funct3;
            dec_imm     = {{(xlen-12){i_insn.i.imm[11]}}, i_insn.i.imm};
            // Only SRAI uses the upper immediate bits as a selector
            alt         = i_insn.i.imm[11:5] == funct7_alt && f3 == f3_sr;
        end else begin
            dec_rs1 = i_insn.r.rs1;
            dec_rs2 = i_insn.r.rs2;
            f3      = i_insn.r.funct3;
            alt     = i_insn.r.funct7 == funct7_alt;
            if (i_insn.r.funct7 == funct7_muldiv) begin
                dec_unit = unit_mul;
            end
        end

        case (f3)
            f3_add:  dec_alu_op = alt ? alu_sub : alu_add;
            f3_sll:  dec_alu_op = alu_sll;
            f3_slt:  dec_alu_op = alu_slt;
            f3_sltu: dec_alu_op = alu_sltu;
            f3_xor:  dec_alu_op = alu_xor;
            f3_sr:   dec_alu_op = alt ? alu_sra : alu_srl;
            f3_or:   dec_alu_op = alu_or;
            default: dec_alu_op = alu_and;
        endcase
    end

    // Forwarding, youngest producer first
    assign src_sel[0] = slot_rs1;
    assign src_sel[1] = slot_rs2;
    assign src_rf[0]  = i_rs1_data;
    assign src_rf[1]  = i_rs2_data;

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            src_val[k]   = src_rf[k];
            src_stall[k] = 1'b0;
            if (src_sel[k] != '0 && fwd.ex1_pending && fwd.ex1_rd == src_sel[k]) begin
                src_val[k]   = fwd.ex1_data;
                src_stall[k] = !fwd.ex1_data_valid;
            end else if (src_sel[k] != '0 && fwd.ex2_pending && fwd.ex2_rd == src_sel[k]) begin
                src_val[k]   = fwd.ex2_data;
                src_stall[k] = !fwd.ex2_data_valid;
            end
        end
    end

    assign can_issue = slot_valid && src_stall == 2'b00 && fwd.ex1_free &&
                       (slot_unit != unit_mul || i_mul_ready);
    assign o_ready   = !slot_valid || can_issue;
    assign o_rs1_sel = slot_rs1;
    assign o_rs2_sel = slot_rs2;

    assign issue.issue_valid = can_issue;
    assign issue.unit        = slot_unit;
    assign issue.alu_op      = slot_alu_op;
    assign issue.mul_op      = slot_mul_op;
    assign issue.rd          = slot_rd;
    assign issue.operand_a   = src_val[0];
    assign issue.operand_b   = slot_use_imm ? slot_imm : src_val[1];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            slot_valid <= 1'b0;
        end else if (i_valid && o_ready) begin
            slot_valid <= 1'b1;
        end else if (can_issue) begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid && o_ready) begin
            slot_unit    <= dec_unit;
            slot_alu_op  <= dec_alu_op;
            slot_mul_op  <= mul_op_e'(f3[1:0]);
            slot_rd      <= i_insn.r.rd;
            slot_rs1     <= dec_rs1;
            slot_rs2     <= dec_rs2;
            slot_use_imm <= dec_use_imm;
            slot_imm     <= dec_imm;
        end
    end

endmodule

// ==== list.f ====
ex_pkg.sv
ex_stage_if.sv
reg_file.sv
alu_unit.sv
mul_unit.sv
result_pipe.sv
issue_stage.sv
exec_core.sv
exec_core_assert.sv
tb_checker.sv
tb_exec_core.sv

// ==== mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit import ex_pkg::*; (
    input  logic            clk,
    input  logic            resetn,
    ex_issue_if.exec        exec,
    output logic            o_ready,
    output logic            o_valid,
    output logic [xlen-1:0] o_result
);

    logic                    start;
    logic                    a_signed;
    logic                    b_signed;
    logic                    a_neg;
    logic                    b_neg;
    logic [xlen-1:0]         mag_a;
    logic [xlen-1:0]         mag_b;
    logic                    busy;
    logic [$clog2(xlen)-1:0] count;
    logic [2*xlen-1:0]       acc;
    logic [2*xlen-1:0]       acc_next;
    logic [2*xlen-1:0]       mcand;
    logic [2*xlen-1:0]       product;
    logic [xlen-1:0]         mplier;
    logic                    neg;
    mul_op_e                 op;

    assign start    = exec.issue_valid && exec.unit == unit_mul;
    assign a_signed = exec.mul_op == mul_mulh || exec.mul_op == mul_mulhsu;
    assign b_signed = exec.mul_op == mul_mulh;
    assign a_neg    = a_signed && exec.operand_a[xlen-1];
    assign b_neg    = b_signed && exec.operand_b[xlen-1];
    assign mag_a    = a_neg ? -exec.operand_a : exec.operand_a;
    assign mag_b    = b_neg ? -exec.operand_b : exec.operand_b;

    // One multiplier bit per cycle, LSB first
    assign acc_next = mplier[0] ? acc + mcand : acc;
    assign product  = neg ? -acc_next : acc_next;
    assign o_ready  = !busy;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy    <= 1'b0;
            count   <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == xlen-1) begin
                    busy    <= 1'b0;
                    o_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= '0;
            mcand  <= {{xlen{1'b0}}, mag_a};
            mplier <= mag_b;
            neg    <= a_neg ^ b_neg;
            op     <= exec.mul_op;
        end else if (busy) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            // The sign-corrected product is final on the last step
            if (count == xlen-1) begin
                o_result <= (op == mul_mul) ? product[xlen-1:0] : product[2*xlen-1:xlen];
            end
        end
    end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file import ex_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [reg_addr_w-1:0] i_rs1_sel,
    output logic [xlen-1:0]       o_rs1_data,
    input  logic [reg_addr_w-1:0] i_rs2_sel,
    output logic [xlen-1:0]       o_rs2_data,
    input  logic                  i_we,
    input  logic [reg_addr_w-1:0] i_wd_sel,
    input  logic [xlen-1:0]       i_wd_data
);

    logic [xlen-1:0] regs [2**reg_addr_w];

    // x0 is hardwired to zero
    assign o_rs1_data = (i_rs1_sel == '0) ? '0 : regs[i_rs1_sel];
    assign o_rs2_data = (i_rs2_sel == '0) ? '0 : regs[i_rs2_sel];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int k = 0; k < 2**reg_addr_w; k++) begin
                regs[k] <= '0;
            end
        end else if (i_we && i_wd_sel != '0) begin
            regs[i_wd_sel] <= i_wd_data;
        end
    end

endmodule

// ==== result_pipe.sv ====
`timescale 1ns/1ps

module result_pipe import ex_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    ex_issue_if.track             track,
    input  logic [xlen-1:0]       i_alu_result,
    input  logic                  i_mul_valid,
    input  logic [xlen-1:0]       i_mul_result,
    ex_fwd_if.source              fwd,
    output logic                  o_wb_valid,
    output logic [reg_addr_w-1:0] o_wb_rd,
    output logic [xlen-1:0]       o_wb_data
);

    logic                  ex1_pending;
    logic                  ex1_wait;
    logic [reg_addr_w-1:0] ex1_rd;
    logic [xlen-1:0]       ex1_result;
    logic                  ex1_data_valid;
    logic [xlen-1:0]       ex1_data;
    logic                  ex1_move;

    logic                  ex2_pending;
    logic                  ex2_wait;
    logic [reg_addr_w-1:0] ex2_rd;
    logic [xlen-1:0]       ex2_result;
    logic                  ex2_data_valid;
    logic [xlen-1:0]       ex2_data;
    logic                  ex2_retire;

    // At most one multiply is in flight, so a product always belongs to the waiting stage
    assign ex1_data_valid = !ex1_wait || i_mul_valid;
    assign ex1_data       = ex1_wait ? i_mul_result : ex1_result;
    assign ex2_data_valid = !ex2_wait || i_mul_valid;
    assign ex2_data       = ex2_wait ? i_mul_result : ex2_result;

    assign ex2_retire = ex2_pending && ex2_data_valid;
    assign ex1_move   = ex1_pending && (!ex2_pending || ex2_retire);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ex1_pending <= 1'b0;
            ex1_wait    <= 1'b0;
        end else if (track.issue_valid) begin
            ex1_pending <= 1'b1;
            ex1_wait    <= track.unit == unit_mul;
        end else if (ex1_move) begin
            ex1_pending <= 1'b0;
            ex1_wait    <= 1'b0;
        end else if (ex1_wait && i_mul_valid) begin
            ex1_wait <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (track.issue_valid) begin
            ex1_rd     <= track.rd;
            ex1_result <= i_alu_result;
        end else if (ex1_wait && i_mul_valid) begin
            ex1_result <= i_mul_result;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ex2_pending <= 1'b0;
            ex2_wait    <= 1'b0;
        end else if (ex1_move) begin
            ex2_pending <= 1'b1;
            ex2_wait    <= !ex1_data_valid;
        end else if (ex2_retire) begin
            ex2_pending <= 1'b0;
            ex2_wait    <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ex1_move) begin
            ex2_rd     <= ex1_rd;
            ex2_result <= ex1_data;
        end
    end

    assign o_wb_valid = ex2_retire;
    assign o_wb_rd    = ex2_rd;
    assign o_wb_data  = ex2_data;

    assign fwd.ex1_pending    = ex1_pending;
    assign fwd.ex1_rd         = ex1_rd;
    assign fwd.ex1_data_valid = ex1_data_valid;
    assign fwd.ex1_data       = ex1_data;
    assign fwd.ex2_pending    = ex2_pending;
    assign fwd.ex2_rd         = ex2_rd;
    assign fwd.ex2_data_valid = ex2_data_valid;
    assign fwd.ex2_data       = ex2_data;
    assign fwd.ex1_free       = !ex1_pending || ex1_move;

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker import ex_pkg::*; (
    input logic                  clk,
    input logic                  resetn,
    input logic                  i_wb_valid,
    input logic [reg_addr_w-1:0] i_wb_rd,
    input logic [xlen-1:0]       i_wb_data
);

    // Expected retirements in program order
    string                 exp_name [$];
    logic [reg_addr_w-1:0] exp_rd   [$];
    logic [xlen-1:0]       exp_data [$];

    int outstanding = 0;
    int pass_count  = 0;
    int error_count = 0;

    task automatic push_expect(input string name, input logic [reg_addr_w-1:0] rd,
                               input logic [xlen-1:0] data);
        exp_name.push_back(name);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
        outstanding++;
    endtask

    // Sampled on the rising edge, where the writeback outputs are settled
    always @(posedge clk) begin
        string                 name;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
        if (resetn && i_wb_valid) begin
            if (exp_name.size() == 0) begin
                $display("Unexpected retirement: x%0d written with %h while nothing was outstanding",
                         i_wb_rd, i_wb_data);
                error_count++;
            end else begin
                name = exp_name.pop_front();
                rd   = exp_rd.pop_front();
                data = exp_data.pop_front();
                outstanding--;
                if (i_wb_rd !== rd || i_wb_data !== data) begin
                    $display("Mismatch %s: expected x%0d = %h, actual x%0d = %h",
                             name, rd, data, i_wb_rd, i_wb_data);
                    error_count++;
                end else begin
                    $display("ok       %s: x%0d = %h", name, i_wb_rd, i_wb_data);
                    pass_count++;
                end
            end
        end
    end

endmodule

// ==== tb_exec_core.sv ====
`timescale 1ns/1ps

module tb_exec_core import ex_pkg::*; ();

    localparam int accept_limit = 200;
    localparam int drain_limit  = 400;

    logic        clk = 1'b0;
    logic        resetn;
    logic        valid;
    logic        ready;
    logic [31:0] insn;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    // Stimulus table, one entry per instruction
    string       tbl_name [$];
    logic [31:0] tbl_insn [$];
    logic [4:0]  tbl_rd   [$];
    logic [31:0] tbl_data [$];
    bit          tbl_b2b  [$];

    int tb_errors;
    int mul_stall_cycles;
    bit hung;

    exec_core dut_i (
        .clk        (clk),
        .resetn     (resetn),
        .i_valid    (valid),
        .o_ready    (ready),
        .i_insn     (insn),
        .o_wb_valid (wb_valid),
        .o_wb_rd    (wb_rd),
        .o_wb_data  (wb_data)
    );

    tb_checker checker_i (
        .clk        (clk),
        .resetn     (resetn),
        .i_wb_valid (wb_valid),
        .i_wb_rd    (wb_rd),
        .i_wb_data  (wb_data)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] enc_op(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opc_op};
    endfunction

    function automatic logic [31:0] enc_imm(input logic [2:0] f3, input int rd,
                                            input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc_op_imm};
    endfunction

    function automatic bit is_multiply(input logic [31:0] word);
        return word[6:0] == opc_op && word[31:25] == funct7_muldiv;
    endfunction

    task automatic add_test(input string name, input logic [31:0] word, input int rd,
                            input logic [31:0] data, input int b2b);
        tbl_name.push_back(name);
        tbl_insn.push_back(word);
        tbl_rd.push_back(rd[4:0]);
        tbl_data.push_back(data);
        tbl_b2b.push_back(b2b != 0);
    endtask

    // Expected values assume serial execution from an all-zero register file
    task automatic build_table();
        add_test("addi_pos", enc_imm(f3_add, 1, 0, 5), 1, 32'h0000_0005, 0);
        add_test("addi_neg", enc_imm(f3_add, 2, 0, -3), 2, 32'hFFFF_FFFD, 0);
        add_test("addi_max", enc_imm(f3_add, 3, 0, 'h7FF), 3, 32'h0000_07FF, 0);
        add_test("addi_min", enc_imm(f3_add, 4, 0, -2048), 4, 32'hFFFF_F800, 0);
        add_test("addi_x0", enc_imm(f3_add, 0, 0, 9), 0, 32'h0000_0009, 0);
        // x0 source right behind the x0 write
        add_test("read_x0", enc_op(7'd0, f3_add, 5, 0, 1), 5, 32'h0000_0005, 1);
        add_test("add", enc_op(7'd0, f3_add, 6, 1, 2), 6, 32'h0000_0002, 0);
        add_test("sub", enc_op(funct7_alt, f3_add, 7, 1, 2), 7, 32'h0000_0008, 0);
        add_test("sll", enc_op(7'd0, f3_sll, 8, 1, 1), 8, 32'h0000_00A0, 0);
        add_test("slt", enc_op(7'd0, f3_slt, 9, 2, 1), 9, 32'h0000_0001, 0);
        add_test("sltu", enc_op(7'd0, f3_sltu, 10, 2, 1), 10, 32'h0000_0000, 0);
        add_test("slt_rev", enc_op(7'd0, f3_slt, 16, 1, 2), 16, 32'h0000_0000, 0);
        add_test("sltu_rev", enc_op(7'd0, f3_sltu, 17, 1, 2), 17, 32'h0000_0001, 0);
        add_test("xor", enc_op(7'd0, f3_xor, 11, 3, 4), 11, 32'hFFFF_FFFF, 0);
        add_test("srl", enc_op(7'd0, f3_sr, 12, 2, 1), 12, 32'h07FF_FFFF, 0);
        add_test("sra", enc_op(funct7_alt, f3_sr, 13, 2, 1), 13, 32'hFFFF_FFFF, 0);
        add_test("or", enc_op(7'd0, f3_or, 14, 1, 3), 14, 32'h0000_07FF, 0);
        add_test("and", enc_op(7'd0, f3_and, 15, 2, 3), 15, 32'h0000_07FD, 0);
        add_test("slti", enc_imm(f3_slt, 18, 2, -1), 18, 32'h0000_0001, 0);
        add_test("sltiu", enc_imm(f3_sltu, 19, 1, -1), 19, 32'h0000_0001, 0);
        add_test("xori", enc_imm(f3_xor, 20, 1, -1), 20, 32'hFFFF_FFFA, 0);
        add_test("ori", enc_imm(f3_or, 21, 1, 'hF0), 21, 32'h0000_00F5, 0);
        add_test("andi", enc_imm(f3_and, 22, 3, 'hF0), 22, 32'h0000_00F0, 0);
        add_test("slli", enc_imm(f3_sll, 23, 1, 28), 23, 32'h5000_0000, 0);
        add_test("srli", enc_imm(f3_sr, 24, 4, 4), 24, 32'h0FFF_FF80, 0);
        add_test("srai", enc_imm(f3_sr, 25, 4, 'h404), 25, 32'hFFFF_FF80, 0);
        // Dependent chain with no gaps
        add_test("chain_base", enc_imm(f3_add, 26, 0, 100), 26, 32'h0000_0064, 0);
        add_test("fwd_ex1", enc_imm(f3_add, 26, 26, 1), 26, 32'h0000_0065, 1);
        add_test("fwd_double", enc_op(7'd0, f3_add, 27, 26, 26), 27, 32'h0000_00CA, 1);
        add_test("fwd_ex2", enc_op(funct7_alt, f3_add, 28, 27, 26), 28, 32'h0000_0065, 1);
        add_test("fwd_both", enc_op(7'd0, f3_xor, 29, 28, 27), 29, 32'h0000_00AF, 1);
        // Extreme operands for the multiplier
        add_test("all_ones", enc_imm(f3_add, 30, 0, -1), 30, 32'hFFFF_FFFF, 0);
        add_test("one", enc_imm(f3_add, 31, 0, 1), 31, 32'h0000_0001, 0);
        add_test("int_min", enc_imm(f3_sll, 31, 31, 31), 31, 32'h8000_0000, 0);
        add_test("int_max", enc_imm(f3_sr, 6, 30, 1), 6, 32'h7FFF_FFFF, 0);
        add_test("mul_neg", enc_op(funct7_muldiv, 3'd0, 7, 1, 2), 7, 32'hFFFF_FFF1, 0);
        add_test("mulh_m1", enc_op(funct7_muldiv, 3'd1, 8, 30, 30), 8, 32'h0000_0000, 0);
        add_test("mulh_min", enc_op(funct7_muldiv, 3'd1, 9, 31, 31), 9, 32'h4000_0000, 0);
        add_test("mulhsu_m1", enc_op(funct7_muldiv, 3'd2, 10, 30, 30), 10, 32'hFFFF_FFFF, 0);
        add_test("mulhu_max", enc_op(funct7_muldiv, 3'd3, 11, 30, 30), 11, 32'hFFFF_FFFE, 0);
        add_test("mulh_mix", enc_op(funct7_muldiv, 3'd1, 12, 31, 6), 12, 32'hC000_0000, 0);
        add_test("mulhu_mix", enc_op(funct7_muldiv, 3'd3, 13, 31, 6), 13, 32'h3FFF_FFFF, 0);
        add_test("mul_max", enc_op(funct7_muldiv, 3'd0, 14, 6, 6), 14, 32'h0000_0001, 0);
        add_test("mulhsu_min", enc_op(funct7_muldiv, 3'd2, 15, 31, 1), 15, 32'hFFFF_FFFD, 0);
        // ALU consumers right behind a multiply
        add_test("mul_dep", enc_op(funct7_muldiv, 3'd0, 16, 3, 3), 16, 32'h003F_F001, 0);
        add_test("use_product", enc_imm(f3_add, 17, 16, 1), 17, 32'h003F_F002, 1);
        add_test("use_both", enc_op(7'd0, f3_add, 18, 16, 17), 18, 32'h007F_E003, 1);
    endtask

    task automatic check_idle(input string when);
        if (wb_valid !== 1'b0 || ready !== 1'b1) begin
            $display("Mismatch reset_idle (%s): expected o_wb_valid=0 o_ready=1, %s%b %s%b",
                     when, "actual o_wb_valid=", wb_valid, "o_ready=", ready);
            tb_errors++;
        end
    endtask

    task automatic apply_entry(input int idx);
        int gap;
        int waited;
        gap = tbl_b2b[idx] ? 0 : int'($urandom_range(3, 0));
        @(negedge clk);
        valid = 1'b0;
        repeat (gap) @(negedge clk);
        valid  = 1'b1;
        insn   = tbl_insn[idx];
        waited = 0;
        while (!ready && waited < accept_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!ready) begin
            $display("Timeout: %s was not accepted within %0d cycles",
                     tbl_name[idx], accept_limit);
            tb_errors++;
            hung = 1'b1;
        end else begin
            checker_i.push_expect(tbl_name[idx], tbl_rd[idx], tbl_data[idx]);
            if (idx > 0 && is_multiply(tbl_insn[idx-1])) begin
                mul_stall_cycles += waited;
            end
            @(posedge clk);
        end
    endtask

    initial begin
        int idx;
        int waited;
        resetn           = 1'b0;
        valid            = 1'b0;
        insn             = '0;
        tb_errors        = 0;
        mul_stall_cycles = 0;
        hung             = 1'b0;
        void'($urandom(32'h61df57cc));
        build_table();

        // Outputs idle through reset and one cycle after
        repeat (3) begin
            @(negedge clk);
            check_idle("in reset");
        end
        resetn = 1'b1;
        @(negedge clk);
        check_idle("after reset");
        if (tb_errors == 0) begin
            $display("ok       reset_idle");
        end

        idx = 0;
        while (idx < tbl_name.size() && !hung) begin
            apply_entry(idx);
            idx++;
        end
        @(negedge clk);
        valid = 1'b0;

        waited = 0;
        while (checker_i.outstanding > 0 && waited < drain_limit) begin
            @(negedge clk);
            waited++;
        end
        if (checker_i.outstanding > 0) begin
            $display("Timeout: %0d instructions never retired", checker_i.outstanding);
            tb_errors++;
        end
        if (mul_stall_cycles == 0) begin
            $display("o_ready never dropped for an instruction queued behind a multiply");
            tb_errors++;
        end

        $display("Summary: %0d passed, %0d mismatched, %0d other errors, %0d of %0d retired",
                 checker_i.pass_count, checker_i.error_count, tb_errors,
                 checker_i.pass_count + checker_i.error_count, tbl_name.size());
        if (tb_errors == 0 && checker_i.error_count == 0 &&
            checker_i.pass_count == tbl_name.size()) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
